// File: common/ea_config.svh
// ------------------------------------------------------------
// Effective-address unit sizing
// Address width, register count and the null register code
// ------------------------------------------------------------
`ifndef EA_CONFIG_SVH
`define EA_CONFIG_SVH

`define EA_ADDR_W   24          // Memory address width
`define EA_NUM_REGS 16          // 32-bit address registers
`define EA_NULL_REG 8'h40       // Register code that reads zero

`endif

// File: common/ea_pkg.sv
// ------------------------------------------------------------
// Effective-address unit types
// Mode enumeration, register codes, addresses and step codes
// ------------------------------------------------------------
`include "ea_config.svh"

package ea_pkg;

    typedef enum logic [3:0] {
        reg_disp,               // (r32) and (r32+d8)
        abs8,
        abs16,
        abs24,
        reg_d16,                // Two phases
        reg_r8,
        reg_r16,
        pre_dec,                // (-r32)
        post_inc,               // (r32+)
        none
    } ea_mode_e;

    typedef logic [7:0]             reg_code_t;    // [5:2] register, [1:0] byte/half
    typedef logic [`EA_ADDR_W-1:0]  ea_addr_t;
    typedef logic [1:0]             step_t;        // 0:1 1:2 2:4

    // Byte count for a step code, the reserved code moves nothing
    function automatic logic [2:0] step_bytes(input step_t code);
        case (code)
            2'd0:    step_bytes = 3'd1;
            2'd1:    step_bytes = 3'd2;
            2'd2:    step_bytes = 3'd4;
            default: step_bytes = 3'd0;
        endcase
    endfunction

endpackage

// File: common/reg_port_if.sv
// ------------------------------------------------------------
// Register bank port between the decoder, bank and adder
// ------------------------------------------------------------
`timescale 1ns/1ps

interface reg_port_if import ea_pkg::*; ();

    reg_code_t   base_sel;      // Index register code
    reg_code_t   aux_sel;       // Offset register code
    logic [31:0] base_data;
    logic [15:0] aux_data;      // Byte in [7:0] or halfword
    step_t       step;
    logic        inc;
    logic        dec;

    modport decoder (output base_sel, aux_sel, step, inc, dec);

    modport bank (input base_sel, aux_sel, step, inc, dec,
                  output base_data, aux_data);

    modport adder (input base_sel, aux_sel, base_data, aux_data, step, inc, dec);

endinterface

// File: dv/ea_checker.sv
// ------------------------------------------------------------
// Effective-address checker
// Shadow register file, expected addresses and error counts
// ------------------------------------------------------------
`timescale 1ns/1ps

module ea_checker
    import ea_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] op,
    input  logic        op_valid,
    input  logic [2:0]  fetched,
    input  logic        wr_en,
    input  logic [3:0]  wr_idx,
    input  logic [31:0] wr_data,
    input  logic        ea_valid,
    input  ea_addr_t    ea_addr,
    input  ea_mode_e    exp_mode,       // Mode class of the current row
    input  logic [2:0]  exp_fetched,    // Bytes consumed in phase one
    input  int          row,
    output int          checks,
    output int          errors
);

    logic [31:0] shadow [16];
    logic [31:0] win1;                  // Phase-one window of a long form
    logic        second;
    logic        pend;
    int          wait_cnt;
    ea_addr_t    exp_addr;
    ea_mode_e    pend_mode;
    logic [3:0]  pend_idx;
    logic [31:0] pend_step;

    function automatic logic [31:0] step_size(input logic [1:0] code);
        case (code)
            2'd0:    return 32'd1;
            2'd1:    return 32'd2;
            2'd2:    return 32'd4;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] reg_value(input logic [7:0] code);
        if (code == 8'h40) begin
            return 32'd0;                   // Null register
        end
        return shadow[code[5:2]];
    endfunction

    task automatic predict(input logic [31:0] w1, input logic [31:0] w2);
        logic [31:0] base;
        logic [31:0] aux;
        logic [31:0] off;
        logic [31:0] sum;
        logic [7:0]  byte_v;
        logic [15:0] half_v;
        base      = reg_value({w1[15:10], 2'b00});
        off       = 32'd0;
        pend_idx  = w1[13:10];
        pend_step = step_size(w1[9:8]);
        case (exp_mode)
            reg_disp: begin
                if (!w1[6]) begin           // Short form, upper eight registers
                    base = shadow[{1'b1, w1[2:0]}];
                    off  = w1[3] ? {{24{w1[15]}}, w1[15:8]} : 32'd0;
                end
            end
            abs8: begin
                base = 32'd0;
                off  = {24'd0, w1[15:8]};
            end
            abs16: begin
                base = 32'd0;
                off  = {16'd0, w1[23:8]};
            end
            abs24: begin
                base = 32'd0;
                off  = {8'd0, w1[31:8]};
            end
            reg_d16: off = {{16{w2[15]}}, w2[15:0]};
            reg_r8, reg_r16: begin
                base   = reg_value(w2[7:0]);
                aux    = reg_value(w2[15:8]);
                byte_v = aux[{w2[9:8], 3'b000} +: 8];
                half_v = w2[9] ? aux[31:16] : aux[15:0];
                off    = (exp_mode == reg_r8) ? {{24{byte_v[7]}}, byte_v}
                                              : {{16{half_v[15]}}, half_v};
            end
            default: ;
        endcase
        sum = base + off;
        if (exp_mode == pre_dec) begin
            sum = sum - pend_step;
        end
        exp_addr  = sum[23:0];
        pend_mode = exp_mode;
        pend      = 1'b1;
        wait_cnt  = 0;
    endtask

    // Everything is sampled mid-cycle, away from both edges
    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                shadow[i] = 32'd0;
            end
            second = 1'b0;
            pend   = 1'b0;
        end else begin
            if (wr_en) begin
                shadow[wr_idx] = wr_data;   // Preload snoop
            end
            if (pend) begin
                wait_cnt = wait_cnt + 1;
                if (wait_cnt == 2) begin
                    pend   = 1'b0;
                    checks = checks + 1;
                    if (!ea_valid) begin
                        errors = errors + 1;
                        $display("No ea_valid two cycles after the last op_valid of row %0d at %0t",
                                 row, $time);
                    end else if (ea_addr !== exp_addr) begin
                        errors = errors + 1;
                        $display("[FAIL] %0t: row %0d address %h, expected %h",
                                 $time, row, ea_addr, exp_addr);
                    end
                    if (pend_mode == post_inc) begin
                        shadow[pend_idx] = shadow[pend_idx] + pend_step;
                    end else if (pend_mode == pre_dec) begin
                        shadow[pend_idx] = shadow[pend_idx] - pend_step;
                    end
                end else if (ea_valid) begin
                    errors = errors + 1;
                    $display("ea_valid came too early on row %0d at %0t", row, $time);
                end
            end else if (ea_valid) begin
                errors = errors + 1;
                $display("ea_valid without a pending access on row %0d at %0t", row, $time);
            end
            if (op_valid) begin
                checks = checks + 1;
                if (!second) begin
                    if (fetched !== exp_fetched) begin
                        errors = errors + 1;
                        $display("[FAIL] %0t: row %0d fetched %0d, expected %0d",
                                 $time, row, fetched, exp_fetched);
                    end
                    if (exp_mode inside {reg_d16, reg_r8, reg_r16}) begin
                        second = 1'b1;
                        win1   = op;
                    end else begin
                        predict(op, 32'd0);
                    end
                end else begin
                    if (fetched !== 3'd2) begin
                        errors = errors + 1;
                        $display("[FAIL] %0t: row %0d phase two fetched %0d, expected 2",
                                 $time, row, fetched);
                    end
                    second = 1'b0;
                    predict(win1, op);
                end
            end
        end
    end

endmodule

// File: dv/ea_tb.sv
// ------------------------------------------------------------
// Effective-address unit testbench
// Register preload, table-driven opcode windows and watchdog
// ------------------------------------------------------------
`timescale 1ns/1ps

module ea_tb
    import ea_pkg::*;
();

    typedef struct {
        logic [31:0] win1;
        logic [2:0]  fetch1;
        logic        two;                   // Needs a phase-two window
        logic [31:0] win2;
        ea_mode_e    mode;
    } row_t;

    logic        clk;
    logic        rst;
    logic [31:0] op;
    logic        op_valid;
    logic [2:0]  fetched;
    logic        wr_en;
    logic [3:0]  wr_idx;
    logic [31:0] wr_data;
    logic        ea_valid;
    ea_addr_t    ea_addr;
    ea_mode_e    exp_mode;
    logic [2:0]  exp_fetched;
    int          row;
    int          checks;
    int          chk_errors;
    int          tb_errors;
    logic [31:0] rng;
    row_t        rows [$];

    ea_unit_top uut (
        .clk      (clk),
        .rst      (rst),
        .op       (op),
        .op_valid (op_valid),
        .fetched  (fetched),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .ea_valid (ea_valid),
        .ea_addr  (ea_addr)
    );

    ea_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .op          (op),
        .op_valid    (op_valid),
        .fetched     (fetched),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .ea_valid    (ea_valid),
        .ea_addr     (ea_addr),
        .exp_mode    (exp_mode),
        .exp_fetched (exp_fetched),
        .row         (row),
        .checks      (checks),
        .errors      (chk_errors)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_row(input logic [31:0] w1, input logic [2:0] f1, input logic two,
                           input logic [31:0] w2, input ea_mode_e mode);
        row_t r;
        r.win1   = w1;
        r.fetch1 = f1;
        r.two    = two;
        r.win2   = w2;
        r.mode   = mode;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(32'h0000_800B, 3'd2, 1'b0, 32'h0, reg_disp);           // (XR11-128)
        add_row(32'h0000_7F0F, 3'd2, 1'b0, 32'h0, reg_disp);
        add_row(32'hA5A5_A505, 3'd1, 1'b0, 32'h0, reg_disp);           // Plain XR13
        add_row(32'hDEAD_9C40, 3'd2, 1'b0, 32'h0, abs8);
        add_row(32'h12BE_EF41, 3'd3, 1'b0, 32'h0, abs16);
        add_row(32'hFEDC_BA42, 3'd4, 1'b0, 32'h0, abs24);
        add_row(32'h0000_0843, 3'd2, 1'b0, 32'h0, reg_disp);           // Long form XR2
        add_row(32'h0000_1143, 3'd2, 1'b1, 32'h0000_8001, reg_d16);
        add_row(32'h0000_1D43, 3'd2, 1'b1, 32'hFFFF_1234, reg_d16);
        add_row(32'h0000_1A43, 3'd2, 1'b1, 32'h0000_2704, reg_r8);     // Byte 3 of XR9
        add_row(32'h0000_1A43, 3'd2, 1'b1, 32'h0000_0D40, reg_r8);     // Null base
        add_row(32'h0000_1643, 3'd2, 1'b1, 32'h0000_2A30, reg_r16);
        add_row(32'h0000_1643, 3'd2, 1'b1, 32'h0000_1808, reg_r16);
        add_row(32'h0000_0C45, 3'd2, 1'b0, 32'h0, post_inc);           // (XR3+) by 1
        add_row(32'h0000_0C43, 3'd2, 1'b0, 32'h0, reg_disp);
        add_row(32'h0000_0D44, 3'd2, 1'b0, 32'h0, pre_dec);            // (-XR3) by 2
        add_row(32'h0000_0C43, 3'd2, 1'b0, 32'h0, reg_disp);
        add_row(32'h0000_2A45, 3'd2, 1'b0, 32'h0, post_inc);           // (XR10+) by 4
        add_row(32'h0000_0002, 3'd1, 1'b0, 32'h0, reg_disp);
        add_row(32'h0000_2A44, 3'd2, 1'b0, 32'h0, pre_dec);
        add_row(32'h0000_0002, 3'd1, 1'b0, 32'h0, reg_disp);
        add_row(32'h0000_3844, 3'd2, 1'b0, 32'h0, pre_dec);            // (-XR14) by 1
        add_row(32'h0000_0006, 3'd1, 1'b0, 32'h0, reg_disp);
        add_row(32'h0000_3945, 3'd2, 1'b0, 32'h0, post_inc);
        add_row(32'h0000_0006, 3'd1, 1'b0, 32'h0, reg_disp);
    endtask

    task automatic step_clk();
        @(posedge clk);
        #1;
    endtask

    task automatic preload_regs();
        for (int i = 0; i < 16; i++) begin
            rng     = xorshift(rng);
            wr_en   = 1'b1;
            wr_idx  = 4'(i);
            wr_data = rng;
            step_clk();
        end
        wr_en = 1'b0;
    endtask

    task automatic send_window(input logic [31:0] w);
        op       = w;
        op_valid = 1'b1;
        step_clk();
        op_valid = 1'b0;
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        while (!ea_valid && n < 8) begin
            step_clk();
            n++;
        end
        if (!ea_valid) begin
            tb_errors++;
            $display("Timed out waiting for ea_valid on row %0d at %0t", row, $time);
        end
        step_clk();
    endtask

    task automatic watchdog();
        int limit;
        limit = rows.size() * 20 + 5;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the table finished", limit);
        $display("Result: FAILED");
        $finish;
    endtask

    initial begin
        rst         = 1'b1;
        op          = 32'd0;
        op_valid    = 1'b0;
        wr_en       = 1'b0;
        wr_idx      = 4'd0;
        wr_data     = 32'd0;
        exp_mode    = none;
        exp_fetched = 3'd0;
        row         = -1;
        tb_errors   = 0;
        rng         = 32'h2009_95bf;
        build_table();
        fork
            watchdog();
        join_none
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        preload_regs();
        foreach (rows[i]) begin
            row         = i;
            exp_mode    = rows[i].mode;
            exp_fetched = rows[i].fetch1;
            send_window(rows[i].win1);
            if (rows[i].two) begin
                step_clk();                 // Idle gap before phase two
                send_window(rows[i].win2);
            end
            wait_result();
        end
        step_clk();
        $display("Checks %0d, errors %0d (checker %0d, testbench %0d)",
                 checks, chk_errors + tb_errors, chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: ea_unit/ea_adder.sv
// ------------------------------------------------------------
// Address adder
// Base plus extended offset, pre-decrement adjust, output reg
// ------------------------------------------------------------
`timescale 1ns/1ps

module ea_adder
    import ea_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    reg_port_if.adder   regs,
    input  ea_addr_t    offset,
    input  logic        use_aux,
    input  logic        aux_wide,
    input  logic        addr_go,
    output logic        ea_valid,
    output ea_addr_t    ea_addr
);

    ea_addr_t aux_ext;
    ea_addr_t sel_off;
    ea_addr_t pre_adj;
    ea_addr_t sum;

    assign aux_ext = aux_wide ? {{8{regs.aux_data[15]}}, regs.aux_data}
                              : {{16{regs.aux_data[7]}}, regs.aux_data[7:0]};
    assign sel_off = use_aux ? aux_ext : offset;
    assign pre_adj = regs.dec ? ea_addr_t'(step_bytes(regs.step)) : '0;    // (-r32)
    assign sum     = ea_addr_t'(regs.base_data) - pre_adj + sel_off;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) ea_valid <= 1'b0;
        else     ea_valid <= addr_go;
    end

    always_ff @(posedge clk) begin
        if (addr_go) ea_addr <= sum;
    end

endmodule

// File: ea_unit/ea_decode.sv
// ------------------------------------------------------------
// Addressing-mode decoder
// Consumes opcode windows over one or two phases and sets up
// register selects, offset and the base register update
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "ea_config.svh"

module ea_decode
    import ea_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] op,         // Lowest byte first
    input  logic        op_valid,
    output logic [2:0]  fetched,
    reg_port_if.decoder regs,
    output ea_addr_t    offset,
    output logic        use_aux,
    output logic        aux_wide,
    output logic        addr_go
);

    ea_mode_e  mode, nx_mode;
    logic      phase, nx_phase;
    logic      done;
    reg_code_t nx_base_sel, nx_aux_sel;
    ea_addr_t  nx_offset;
    step_t     nx_step;
    logic      nx_use_aux, nx_aux_wide, nx_inc, nx_dec;

    // Short-form register field maps onto the upper eight registers
    function automatic reg_code_t full_reg(input logic [2:0] rcode);
        full_reg = {3'b111, rcode, 2'b00};
    endfunction

    always_comb begin
        fetched     = 3'd0;
        done        = 1'b0;
        nx_mode     = mode;
        nx_phase    = phase;
        nx_base_sel = regs.base_sel;
        nx_aux_sel  = regs.aux_sel;
        nx_offset   = offset;
        nx_step     = regs.step;
        nx_use_aux  = use_aux;
        nx_aux_wide = aux_wide;
        nx_inc      = 1'b0;                 // Update lasts one cycle
        nx_dec      = 1'b0;
        if (op_valid && !phase) begin
            nx_use_aux  = 1'b0;
            nx_aux_wide = 1'b0;
            nx_step     = op[9:8];
            casez ({op[6], op[3:0]})
                5'b0_????: begin            // (r32) or (r32+d8)
                    nx_mode     = reg_disp;
                    nx_base_sel = full_reg(op[2:0]);
                    nx_offset   = op[3] ? {{16{op[15]}}, op[15:8]} : '0;
                    fetched     = op[3] ? 3'd2 : 3'd1;
                    done        = 1'b1;
                end
                5'h10, 5'h11, 5'h12: begin  // Absolute address
                    nx_base_sel = `EA_NULL_REG;
                    done        = 1'b1;
                    case (op[1:0])
                        2'd0: begin
                            nx_mode   = abs8;
                            nx_offset = {16'd0, op[15:8]};
                            fetched   = 3'd2;
                        end
                        2'd1: begin
                            nx_mode   = abs16;
                            nx_offset = {8'd0, op[23:8]};
                            fetched   = 3'd3;
                        end
                        default: begin
                            nx_mode   = abs24;
                            nx_offset = op[31:8];
                            fetched   = 3'd4;
                        end
                    endcase
                end
                5'h13: begin                // Long register forms
                    nx_base_sel = {op[15:10], 2'b00};
                    nx_offset   = '0;
                    fetched     = 3'd2;
                    case (op[9:8])
                        2'd0: begin
                            nx_mode = reg_disp;
                            done    = 1'b1;
                        end
                        2'd1: begin
                            nx_mode  = reg_d16;
                            nx_phase = 1'b1;
                        end
                        2'd2: begin
                            nx_mode     = op[10] ? reg_r16 : reg_r8;
                            nx_use_aux  = 1'b1;
                            nx_aux_wide = op[10];
                            nx_phase    = 1'b1;
                        end
                        default: begin      // Reserved, nothing consumed
                            nx_mode = none;
                            fetched = 3'd0;
                        end
                    endcase
                end
                5'h14, 5'h15: begin         // (-r32) and (r32+)
                    nx_mode     = op[0] ? post_inc : pre_dec;
                    nx_base_sel = {op[15:10], 2'b00};
                    nx_offset   = '0;
                    nx_inc      = op[0];
                    nx_dec      = !op[0];
                    fetched     = 3'd2;
                    done        = 1'b1;
                end
                default: nx_mode = none;
            endcase
        end else if (op_valid) begin
            nx_phase = 1'b0;
            fetched  = 3'd2;
            done     = 1'b1;
            case (mode)
                reg_d16: nx_offset = {{8{op[15]}}, op[15:0]};
                reg_r8, reg_r16: begin      // Base and aux codes
                    nx_base_sel = op[7:0];
                    nx_aux_sel  = op[15:8];
                end
                default: done = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= 1'b0;
            mode     <= none;
            addr_go  <= 1'b0;
            regs.inc <= 1'b0;
            regs.dec <= 1'b0;
        end else begin
            phase    <= nx_phase;
            mode     <= nx_mode;
            addr_go  <= done;
            regs.inc <= nx_inc;
            regs.dec <= nx_dec;
        end
    end

    always_ff @(posedge clk) begin
        regs.base_sel <= nx_base_sel;
        regs.aux_sel  <= nx_aux_sel;
        regs.step     <= nx_step;
        offset        <= nx_offset;
        use_aux       <= nx_use_aux;
        aux_wide      <= nx_aux_wide;
    end

endmodule

// File: ea_unit/ea_regbank.sv
// ------------------------------------------------------------
// Address register bank
// Sixteen 32-bit registers, combinational reads, external load
// and post-address increment or decrement of the base register
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "ea_config.svh"

module ea_regbank
    import ea_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en,
    input  logic [3:0]  wr_idx,
    input  logic [31:0] wr_data,
    reg_port_if.bank    regs,
    input  logic        addr_go
);

    logic [31:0] xr [`EA_NUM_REGS];
    logic [31:0] base_word;
    logic [31:0] aux_word;
    logic [31:0] aux_shift;
    logic [31:0] step_val;
    logic [3:0]  base_idx;
    logic        base_null;
    logic        aux_null;
    logic        upd;

    assign base_idx  = regs.base_sel[5:2];
    assign base_null = (regs.base_sel == `EA_NULL_REG);
    assign aux_null  = (regs.aux_sel == `EA_NULL_REG);
    assign base_word = xr[base_idx];
    assign aux_word  = xr[regs.aux_sel[5:2]];

    // Selected byte or halfword lands in the low bits
    assign aux_shift = aux_word >> {regs.aux_sel[1:0], 3'b000};

    assign regs.base_data = base_null ? 32'd0 : base_word;
    assign regs.aux_data  = aux_null ? 16'd0 : aux_shift[15:0];

    assign step_val = {29'd0, step_bytes(regs.step)};
    assign upd      = addr_go && (regs.inc || regs.dec) && !base_null;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `EA_NUM_REGS; i++) begin
                xr[i] <= 32'd0;
            end
        end else begin
            for (int i = 0; i < `EA_NUM_REGS; i++) begin
                if (wr_en && wr_idx == 4'(i)) begin
                    xr[i] <= wr_data;                   // Load wins
                end else if (upd && base_idx == 4'(i)) begin
                    xr[i] <= regs.inc ? xr[i] + step_val
                                      : xr[i] - step_val;
                end
            end
        end
    end

endmodule

// File: rtl/ea_unit_top.sv
// ------------------------------------------------------------
// Effective-address unit top level
// Mode decoder, register bank and address adder
// ------------------------------------------------------------
`timescale 1ns/1ps

module ea_unit_top
    import ea_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] op,
    input  logic        op_valid,
    output logic [2:0]  fetched,
    input  logic        wr_en,          // Register preload
    input  logic [3:0]  wr_idx,
    input  logic [31:0] wr_data,
    output logic        ea_valid,
    output ea_addr_t    ea_addr
);

    reg_port_if regs ();

    ea_addr_t offset;
    logic     use_aux;
    logic     aux_wide;
    logic     addr_go;

    ea_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .op       (op),
        .op_valid (op_valid),
        .fetched  (fetched),
        .regs     (regs.decoder),
        .offset   (offset),
        .use_aux  (use_aux),
        .aux_wide (aux_wide),
        .addr_go  (addr_go)
    );

    ea_regbank u_regbank (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .regs    (regs.bank),
        .addr_go (addr_go)
    );

    ea_adder u_adder (
        .clk      (clk),
        .rst      (rst),
        .regs     (regs.adder),
        .offset   (offset),
        .use_aux  (use_aux),
        .aux_wide (aux_wide),
        .addr_go  (addr_go),
        .ea_valid (ea_valid),
        .ea_addr  (ea_addr)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the effective-address unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module ea_tb -f verilog.f -o ea_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/ea_sim)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Result: PASSED"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: verilog.f
+incdir+common
common/ea_pkg.sv
common/reg_port_if.sv
ea_unit/ea_decode.sv
ea_unit/ea_regbank.sv
ea_unit/ea_adder.sv
rtl/ea_unit_top.sv
dv/ea_checker.sv
dv/ea_tb.sv
